// ==== loader_pkg.sv ====
package loader_pkg;

    // ========================================
    // Basic widths
    // ========================================

    typedef logic [7:0]  byte_t;
    // 6502 side address
    typedef logic [15:0] cpu_addr_t;
    // External memory byte address
    typedef logic [22:0] mem_addr_t;
    // Byte offset inside one download
    typedef logic [24:0] dl_addr_t;

    typedef enum logic [1:0] {
        KIND_NONE,
        KIND_ROM,
        KIND_PRG,
        KIND_TAP
    } load_kind_e;

    // ========================================
    // Host download index codes
    // ========================================

    localparam byte_t IDX_ROM     = 8'h00;
    localparam byte_t IDX_PRG     = 8'h01;
    localparam byte_t IDX_PRG_ALT = 8'h41;
    localparam byte_t IDX_TAP     = 8'h81;

    // Memory map
    localparam mem_addr_t TAP_MEM_START     = 23'h20000;
    localparam cpu_addr_t PRG_CART_BASE     = 16'hA000;
    localparam cpu_addr_t PRG_ADDR_LIMIT    = 16'hBFFF;
    localparam dl_addr_t TAP_VERSION_OFFSET = 25'd12;

    // BASIC start of variables, arrays and free space, then end of program
    localparam cpu_addr_t BASIC_PTR_ADDR [8] = '{
        16'h002D, 16'h002E, 16'h002F, 16'h0030,
        16'h0031, 16'h0032, 16'h00AE, 16'h00AF
    };

endpackage

// ==== download_decoder.sv ====
`timescale 1ns/10ps

module download_decoder (
    input  logic                   clk_sys,
    input  logic                   reset,
    input  logic                   dl_active_i,
    input  loader_pkg::byte_t      dl_index_i,
    input  logic                   dl_wr_i,
    input  loader_pkg::dl_addr_t   dl_addr_i,
    input  loader_pkg::byte_t      dl_data_i,
    output loader_pkg::load_kind_e kind_o,
    output logic                   we_o,
    output loader_pkg::mem_addr_t  addr_o,
    output loader_pkg::byte_t      data_o,
    output loader_pkg::mem_addr_t  tap_end_addr_o,
    output logic                   tap_version_o
);

    loader_pkg::mem_addr_t rom_addr;
    logic                  rom_valid;
    loader_pkg::mem_addr_t tap_next;
    loader_pkg::mem_addr_t tap_wr_addr;
    logic                  rom_wr;
    logic                  tap_wr;

    always_comb begin
        kind_o = loader_pkg::KIND_NONE;
        if (dl_active_i) begin
            case (dl_index_i)
                loader_pkg::IDX_ROM:                      kind_o = loader_pkg::KIND_ROM;
                loader_pkg::IDX_PRG, loader_pkg::IDX_PRG_ALT: kind_o = loader_pkg::KIND_PRG;
                loader_pkg::IDX_TAP:                      kind_o = loader_pkg::KIND_TAP;
                default:                                  kind_o = loader_pkg::KIND_NONE;
            endcase
        end
    end

    // ROM image regions, 8K steps of the download offset
    always_comb begin
        rom_valid = (dl_addr_i[24:16] == 9'h000);
        rom_addr  = '0;
        case (dl_addr_i[15:13])
            3'b000, 3'b001: rom_addr = {9'h000, dl_addr_i[13:0]};  // drive ROM
            3'b010:         rom_addr = {10'h007, dl_addr_i[12:0]}; // PAL kernal
            3'b011:         rom_addr = {10'h00F, dl_addr_i[12:0]}; // NTSC kernal
            3'b100:         rom_addr = {10'h006, dl_addr_i[12:0]}; // BASIC
            3'b101:         rom_addr = {11'h008, dl_addr_i[11:0]}; // character ROM
            default:        rom_valid = 1'b0;
        endcase
    end

    // Tape image restarts at the tape area on offset 0
    assign tap_wr_addr    = (dl_addr_i == '0) ? loader_pkg::TAP_MEM_START : tap_next;
    assign tap_end_addr_o = tap_next;

    assign rom_wr = dl_wr_i && (kind_o == loader_pkg::KIND_ROM) && rom_valid;
    assign tap_wr = dl_wr_i && (kind_o == loader_pkg::KIND_TAP);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            we_o          <= 1'b0;
            tap_next      <= loader_pkg::TAP_MEM_START;
            tap_version_o <= 1'b0;
        end else begin
            we_o <= rom_wr || tap_wr;
            if (tap_wr) begin
                tap_next <= tap_wr_addr + 23'd1;
                if (dl_addr_i == loader_pkg::TAP_VERSION_OFFSET) begin
                    tap_version_o <= dl_data_i[0];
                end
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rom_wr) begin
            addr_o <= rom_addr;
            data_o <= dl_data_i;
        end else if (tap_wr) begin
            addr_o <= tap_wr_addr;
            data_o <= dl_data_i;
        end
    end

endmodule

// ==== prg_loader.sv ====
`timescale 1ns/10ps

module prg_loader (
    input  logic                   clk_sys,
    input  logic                   reset,
    input  loader_pkg::load_kind_e kind_i,
    input  logic                   dl_wr_i,
    input  loader_pkg::dl_addr_t   dl_addr_i,
    input  loader_pkg::byte_t      dl_data_i,
    input  logic                   no_header_i,
    output logic                   we_o,
    output loader_pkg::mem_addr_t  addr_o,
    output loader_pkg::byte_t      data_o,
    output logic                   force_reset_o
);

    logic                  prg_active;
    logic                  prg_active_d;
    logic                  hdr_byte;
    logic                  first_data;
    logic                  data_byte;
    loader_pkg::cpu_addr_t prg_addr;
    loader_pkg::cpu_addr_t wr_addr;
    logic [4:0]            inject_step;
    logic                  inject_wr;
    logic [2:0]            ptr_idx;
    logic                  auto_reset;

    assign prg_active = (kind_i == loader_pkg::KIND_PRG);

    // Two byte load address leads the file unless disabled
    assign hdr_byte   = !no_header_i && (dl_addr_i == 25'd0 || dl_addr_i == 25'd1);
    assign first_data = no_header_i ? (dl_addr_i == 25'd0) : (dl_addr_i == 25'd2);
    assign data_byte  = prg_active && dl_wr_i && !hdr_byte;

    // Address stops at the top of the cartridge window
    always_comb begin
        if (first_data) begin
            wr_addr = no_header_i ? loader_pkg::PRG_CART_BASE : prg_addr;
        end else if (prg_addr == loader_pkg::PRG_ADDR_LIMIT) begin
            wr_addr = prg_addr;
        end else begin
            wr_addr = prg_addr + 16'd1;
        end
    end

    // Odd steps 1..15 write one pointer byte each
    assign inject_wr = inject_step[0] && !inject_step[4];
    assign ptr_idx   = inject_step[3:1];

    // ========================================
    // Control
    // ========================================

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            prg_active_d  <= 1'b0;
            inject_step   <= 5'd0;
            auto_reset    <= 1'b0;
            force_reset_o <= 1'b0;
            we_o          <= 1'b0;
        end else begin
            prg_active_d  <= prg_active;
            force_reset_o <= 1'b0;
            we_o          <= data_byte || inject_wr;
            if (data_byte && wr_addr == loader_pkg::PRG_CART_BASE) begin
                auto_reset <= 1'b1;
            end
            // PRG download just ended
            if (prg_active_d && !prg_active) begin
                inject_step <= 5'd1;
            end else if (inject_step != 5'd0) begin
                inject_step <= inject_step + 5'd1;
            end
            if (inject_step == 5'd31) begin
                force_reset_o <= auto_reset;
                auto_reset    <= 1'b0;
            end
        end
    end

    // ========================================
    // Load address and write data
    // ========================================

    always_ff @(posedge clk_sys) begin
        if (prg_active && dl_wr_i) begin
            if (hdr_byte) begin
                if (dl_addr_i[0]) begin
                    prg_addr[15:8] <= dl_data_i;
                end else begin
                    prg_addr[7:0] <= dl_data_i;
                end
            end else begin
                prg_addr <= wr_addr;
                addr_o   <= {7'h00, wr_addr};
                data_o   <= dl_data_i;
            end
        end else if (inject_wr) begin
            // End address, low byte then high byte
            addr_o <= {7'h00, loader_pkg::BASIC_PTR_ADDR[ptr_idx]};
            data_o <= inject_step[1] ? prg_addr[15:8] : prg_addr[7:0];
        end
    end

endmodule

// ==== tape_fetcher.sv ====
`timescale 1ns/10ps

module tape_fetcher #(
    parameter int TAP_FIFO_DEPTH = 4
) (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  logic                  dl_active_i,
    input  logic                  tap_loading_i,
    input  loader_pkg::mem_addr_t tap_end_addr_i,
    input  logic                  p2_h_i,
    output logic                  rd_o,
    output loader_pkg::mem_addr_t rd_addr_o,
    input  loader_pkg::byte_t     rd_data_i,
    output loader_pkg::byte_t     tap_data_o,
    output logic                  tap_valid_o,
    input  logic                  tap_credit_i,
    output logic                  tap_restart_o
);

    localparam int CW = $clog2(TAP_FIFO_DEPTH + 1);
    localparam logic [CW-1:0] CREDIT_MAX = CW'(TAP_FIFO_DEPTH);

    logic                  p2_d;
    logic                  p2_fall;
    logic                  p2_rise;
    logic                  load_d;
    logic                  loading;
    logic                  send;
    loader_pkg::mem_addr_t play_addr;
    loader_pkg::mem_addr_t last_addr;
    logic [CW-1:0]         credits;

    assign p2_fall   = p2_d && !p2_h_i;
    assign p2_rise   = !p2_d && p2_h_i;
    // One extra cycle picks up the end address of the final byte
    assign loading   = tap_loading_i || load_d;
    assign send      = p2_rise && rd_o && !loading;
    assign rd_addr_o = play_addr;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            p2_d          <= 1'b0;
            load_d        <= 1'b0;
            play_addr     <= loader_pkg::TAP_MEM_START;
            last_addr     <= loader_pkg::TAP_MEM_START;
            rd_o          <= 1'b0;
            tap_valid_o   <= 1'b0;
            tap_restart_o <= 1'b0;
            credits       <= CREDIT_MAX;
        end else begin
            p2_d          <= p2_h_i;
            load_d        <= tap_loading_i;
            tap_valid_o   <= send;
            tap_restart_o <= tap_loading_i && !load_d;
            if (loading) begin
                play_addr <= loader_pkg::TAP_MEM_START;
                last_addr <= tap_end_addr_i;
                rd_o      <= 1'b0;
            end else begin
                // Fetch only in the low bus phase
                if (p2_fall && !dl_active_i && play_addr != last_addr && credits != '0) begin
                    rd_o <= 1'b1;
                end
                if (send) begin
                    rd_o      <= 1'b0;
                    play_addr <= play_addr + 23'd1;
                end
            end
            case ({send, tap_credit_i})
                2'b10: credits <= credits - 1'b1;
                2'b01: begin
                    if (credits != CREDIT_MAX) begin
                        credits <= credits + 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // Last sample before p2 rises is the one sent
    always_ff @(posedge clk_sys) begin
        if (!p2_h_i && rd_o) begin
            tap_data_o <= rd_data_i;
        end
    end

endmodule

// ==== mem_arbiter.sv ====
`timescale 1ns/10ps

module mem_arbiter (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  logic                  prg_we_i,
    input  loader_pkg::mem_addr_t prg_addr_i,
    input  loader_pkg::byte_t     prg_data_i,
    input  logic                  dl_we_i,
    input  loader_pkg::mem_addr_t dl_addr_i,
    input  loader_pkg::byte_t     dl_data_i,
    input  logic                  tap_rd_i,
    input  loader_pkg::mem_addr_t tap_addr_i,
    output loader_pkg::mem_addr_t mem_addr_o,
    output loader_pkg::byte_t     mem_wdata_o,
    output logic                  mem_we_o,
    output logic                  mem_oe_o
);

    // Fixed priority, PRG over ROM/TAP writes over tape reads
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            mem_we_o <= 1'b0;
            mem_oe_o <= 1'b0;
        end else begin
            mem_we_o <= prg_we_i || dl_we_i;
            mem_oe_o <= tap_rd_i && !prg_we_i && !dl_we_i;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (prg_we_i) begin
            mem_addr_o  <= prg_addr_i;
            mem_wdata_o <= prg_data_i;
        end else if (dl_we_i) begin
            mem_addr_o  <= dl_addr_i;
            mem_wdata_o <= dl_data_i;
        end else if (tap_rd_i) begin
            mem_addr_o <= tap_addr_i;
        end
    end

endmodule

// ==== loader_top.sv ====
`timescale 1ns/10ps

module loader_top #(
    parameter int TAP_FIFO_DEPTH = 4
) (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  logic                  dl_active_i,
    input  loader_pkg::byte_t     dl_index_i,
    input  logic                  dl_wr_i,
    input  loader_pkg::dl_addr_t  dl_addr_i,
    input  loader_pkg::byte_t     dl_data_i,
    input  logic                  no_header_i,
    input  logic                  p2_h_i,
    input  loader_pkg::byte_t     mem_rdata_i,
    input  logic                  tap_credit_i,
    output loader_pkg::mem_addr_t mem_addr_o,
    output loader_pkg::byte_t     mem_wdata_o,
    output logic                  mem_we_o,
    output logic                  mem_oe_o,
    output logic                  force_reset_o,
    output loader_pkg::byte_t     tap_data_o,
    output logic                  tap_valid_o,
    output logic                  tap_version_o,
    output logic                  tap_restart_o
);

    loader_pkg::load_kind_e kind;
    logic                   rom_tap_we;
    loader_pkg::mem_addr_t  rom_tap_addr;
    loader_pkg::byte_t      rom_tap_data;
    loader_pkg::mem_addr_t  tap_end_addr;
    logic                   prg_we;
    loader_pkg::mem_addr_t  prg_addr;
    loader_pkg::byte_t      prg_data;
    logic                   tap_rd;
    loader_pkg::mem_addr_t  tap_rd_addr;
    logic                   tap_loading;

    assign tap_loading = (kind == loader_pkg::KIND_TAP);

    // ========================================
    // Download path
    // ========================================

    download_decoder u_download_decoder (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .dl_active_i    (dl_active_i),
        .dl_index_i     (dl_index_i),
        .dl_wr_i        (dl_wr_i),
        .dl_addr_i      (dl_addr_i),
        .dl_data_i      (dl_data_i),
        .kind_o         (kind),
        .we_o           (rom_tap_we),
        .addr_o         (rom_tap_addr),
        .data_o         (rom_tap_data),
        .tap_end_addr_o (tap_end_addr),
        .tap_version_o  (tap_version_o)
    );

    prg_loader u_prg_loader (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .kind_i        (kind),
        .dl_wr_i       (dl_wr_i),
        .dl_addr_i     (dl_addr_i),
        .dl_data_i     (dl_data_i),
        .no_header_i   (no_header_i),
        .we_o          (prg_we),
        .addr_o        (prg_addr),
        .data_o        (prg_data),
        .force_reset_o (force_reset_o)
    );

    // Tape playback toward the cassette
    tape_fetcher #(
        .TAP_FIFO_DEPTH (TAP_FIFO_DEPTH)
    ) u_tape_fetcher (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .dl_active_i    (dl_active_i),
        .tap_loading_i  (tap_loading),
        .tap_end_addr_i (tap_end_addr),
        .p2_h_i         (p2_h_i),
        .rd_o           (tap_rd),
        .rd_addr_o      (tap_rd_addr),
        .rd_data_i      (mem_rdata_i),
        .tap_data_o     (tap_data_o),
        .tap_valid_o    (tap_valid_o),
        .tap_credit_i   (tap_credit_i),
        .tap_restart_o  (tap_restart_o)
    );

    mem_arbiter u_mem_arbiter (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .prg_we_i    (prg_we),
        .prg_addr_i  (prg_addr),
        .prg_data_i  (prg_data),
        .dl_we_i     (rom_tap_we),
        .dl_addr_i   (rom_tap_addr),
        .dl_data_i   (rom_tap_data),
        .tap_rd_i    (tap_rd),
        .tap_addr_i  (tap_rd_addr),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_we_o    (mem_we_o),
        .mem_oe_o    (mem_oe_o)
    );

endmodule

// ==== loader_assert.sv ====
`timescale 1ns/10ps

module loader_assert #(
    parameter int TAP_FIFO_DEPTH = 4
) (
    input logic clk_sys,
    input logic reset,
    input logic mem_we_o,
    input logic mem_oe_o,
    input logic tap_valid_o,
    input logic tap_credit_i
);

    int outstanding;

    // Bytes sent to the cassette and not yet drained
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            outstanding <= 0;
        end else if (tap_valid_o && !tap_credit_i) begin
            outstanding <= outstanding + 1;
        end else if (!tap_valid_o && tap_credit_i && outstanding > 0) begin
            outstanding <= outstanding - 1;
        end
    end

    a_no_we_oe: assert property (@(posedge clk_sys) disable iff (reset)
        !(mem_we_o && mem_oe_o))
        else $error("memory write and read enables high together");

    a_credit_limit: assert property (@(posedge clk_sys) disable iff (reset)
        outstanding <= TAP_FIFO_DEPTH)
        else $error("more tape bytes outstanding than FIFO slots");

endmodule

bind loader_top loader_assert #(
    .TAP_FIFO_DEPTH (TAP_FIFO_DEPTH)
) u_loader_assert (
    .clk_sys      (clk_sys),
    .reset        (reset),
    .mem_we_o     (mem_we_o),
    .mem_oe_o     (mem_oe_o),
    .tap_valid_o  (tap_valid_o),
    .tap_credit_i (tap_credit_i)
);

// ==== tb_loader_top.sv ====
`timescale 1ns/10ps

module tb_loader_top;

    localparam int FIFO_DEPTH = 4;

    logic                  clk_sys;
    logic                  reset;
    logic                  dl_active_i;
    loader_pkg::byte_t     dl_index_i;
    logic                  dl_wr_i;
    loader_pkg::dl_addr_t  dl_addr_i;
    loader_pkg::byte_t     dl_data_i;
    logic                  no_header_i;
    logic                  p2_h_i;
    loader_pkg::byte_t     mem_rdata_i;
    logic                  tap_credit_i;
    loader_pkg::mem_addr_t mem_addr_o;
    loader_pkg::byte_t     mem_wdata_o;
    logic                  mem_we_o;
    logic                  mem_oe_o;
    logic                  force_reset_o;
    loader_pkg::byte_t     tap_data_o;
    logic                  tap_valid_o;
    logic                  tap_version_o;
    logic                  tap_restart_o;

    // Sparse memory model and logs of what the DUT did
    loader_pkg::byte_t     mem_model [loader_pkg::mem_addr_t];
    loader_pkg::mem_addr_t wr_addr_q [$];
    loader_pkg::byte_t     wr_data_q [$];
    loader_pkg::byte_t     rx_q [$];
    string                 case_lines [$];
    string                 toks [$];
    int                    reset_pulses;
    int                    restart_pulses;
    int                    outstanding;
    int                    credit_pending;
    int                    credit_wait;
    int                    p2_count;
    int                    cycle_count;
    int                    cycle_limit;

    loader_top #(
        .TAP_FIFO_DEPTH (FIFO_DEPTH)
    ) dut (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .dl_active_i   (dl_active_i),
        .dl_index_i    (dl_index_i),
        .dl_wr_i       (dl_wr_i),
        .dl_addr_i     (dl_addr_i),
        .dl_data_i     (dl_data_i),
        .no_header_i   (no_header_i),
        .p2_h_i        (p2_h_i),
        .mem_rdata_i   (mem_rdata_i),
        .tap_credit_i  (tap_credit_i),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_we_o      (mem_we_o),
        .mem_oe_o      (mem_oe_o),
        .force_reset_o (force_reset_o),
        .tap_data_o    (tap_data_o),
        .tap_valid_o   (tap_valid_o),
        .tap_version_o (tap_version_o),
        .tap_restart_o (tap_restart_o)
    );

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;
    end

    function automatic loader_pkg::byte_t read_mem(loader_pkg::mem_addr_t a);
        if (mem_model.exists(a)) begin
            return mem_model[a];
        end
        return 8'h00;
    endfunction

    assign mem_rdata_i = mem_oe_o ? read_mem(mem_addr_o) : 8'h00;

    // ========================================
    // Checks
    // ========================================

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input loader_pkg::mem_addr_t expected,
                              input loader_pkg::mem_addr_t actual);
        if (expected !== actual) begin
            $display("Error: %s address expected %h actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_byte(input string name, input loader_pkg::byte_t expected,
                              input loader_pkg::byte_t actual);
        if (expected !== actual) begin
            $display("Error: %s byte expected %h actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("Error: %s bit expected %b actual %b", name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // Cycle limit
    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run took more than %0d cycles", cycle_limit);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    // Bus phase, 8 cycles low and 8 high
    always @(negedge clk_sys) begin
        if (p2_count == 7) begin
            p2_count <= 0;
            p2_h_i   <= ~p2_h_i;
        end else begin
            p2_count <= p2_count + 1;
        end
    end

    // ========================================
    // Monitor, memory model and credit return
    // ========================================

    always @(negedge clk_sys) begin
        tap_credit_i <= 1'b0;
        if (!reset) begin
            if (mem_we_o && mem_oe_o) begin
                abort_run("Memory write and read enables were high together");
            end
            if (mem_we_o) begin
                wr_addr_q.push_back(mem_addr_o);
                wr_data_q.push_back(mem_wdata_o);
                mem_model[mem_addr_o] = mem_wdata_o;
            end
            if (force_reset_o) begin
                reset_pulses = reset_pulses + 1;
            end
            if (tap_restart_o) begin
                restart_pulses = restart_pulses + 1;
            end
            if (credit_pending > 0) begin
                if (credit_wait == 0) begin
                    tap_credit_i <= 1'b1;
                    credit_pending = credit_pending - 1;
                    outstanding = outstanding - 1;
                    credit_wait = $urandom % 21;
                end else begin
                    credit_wait = credit_wait - 1;
                end
            end
            if (tap_valid_o) begin
                rx_q.push_back(tap_data_o);
                outstanding = outstanding + 1;
                if (credit_pending == 0) begin
                    credit_wait = $urandom % 21;
                end
                credit_pending = credit_pending + 1;
                if (outstanding > FIFO_DEPTH) begin
                    abort_run("More tape bytes outstanding than cassette FIFO slots");
                end
            end
        end
    end

    // Splits one line of the cases file into tokens
    task automatic split_line(input string s);
        int  start;
        byte c;
        toks.delete();
        start = -1;
        for (int i = 0; i <= s.len(); i++) begin
            c = (i < s.len()) ? s.getc(i) : 8'h20;
            if (c == " " || c == "\t" || c == "\n" || c == "\r") begin
                if (start >= 0) begin
                    toks.push_back(s.substr(start, i - 1));
                end
                start = -1;
            end else if (start < 0) begin
                start = i;
            end
        end
    endtask

    task automatic run_case();
        string name;
        int    idx;
        int    start;
        int    count;
        int    nexp;
        int    pos;
        logic  exp_reset;
        logic  exp_ver;
        name      = toks[0];
        idx       = toks[1].atohex();
        start     = toks[2].atohex();
        exp_reset = toks[4].atohex() != 0;
        exp_ver   = toks[5].atohex() != 0;
        count     = toks[6].atohex();
        nexp      = toks[7 + count].atohex();
        wr_addr_q.delete();
        wr_data_q.delete();
        rx_q.delete();
        reset_pulses   = 0;
        restart_pulses = 0;

        @(negedge clk_sys);
        dl_index_i  = loader_pkg::byte_t'(idx);
        no_header_i = toks[3].atohex() != 0;
        dl_active_i = 1'b1;
        @(negedge clk_sys);
        for (int i = 0; i < count; i++) begin
            dl_wr_i   = 1'b1;
            dl_addr_i = loader_pkg::dl_addr_t'(start + i);
            dl_data_i = loader_pkg::byte_t'(toks[7 + i].atohex());
            @(negedge clk_sys);
            dl_wr_i = 1'b0;
            @(negedge clk_sys);
        end
        repeat (2) @(negedge clk_sys);
        dl_active_i = 1'b0;
        // Pointer patching and the reset decision take 32 cycles
        repeat (40) @(negedge clk_sys);

        if (wr_addr_q.size() != nexp) begin
            abort_run($sformatf("%s: %0d memory writes seen where %0d were expected",
                                name, wr_addr_q.size(), nexp));
        end
        pos = 8 + count;
        for (int j = 0; j < nexp; j++) begin
            check_addr(name, loader_pkg::mem_addr_t'(toks[pos].atohex()), wr_addr_q[j]);
            check_byte(name, loader_pkg::byte_t'(toks[pos + 1].atohex()), wr_data_q[j]);
            pos = pos + 2;
        end
        check_bit(name, exp_reset, reset_pulses != 0);
        if (reset_pulses > 1) begin
            abort_run($sformatf("%s: force reset pulsed more than once", name));
        end

        if (loader_pkg::byte_t'(idx) == loader_pkg::IDX_TAP) begin
            check_bit(name, exp_ver, tap_version_o);
            check_bit(name, 1'b1, restart_pulses == 1);
            while (rx_q.size() < count) begin
                @(negedge clk_sys);
            end
            repeat (40) @(negedge clk_sys);
            if (rx_q.size() != count) begin
                abort_run($sformatf("%s: tape played %0d bytes where %0d were stored",
                                    name, rx_q.size(), count));
            end
            for (int i = 0; i < count; i++) begin
                check_byte(name, loader_pkg::byte_t'(toks[7 + i].atohex()), rx_q[i]);
            end
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial begin
        int    fd;
        int    total_bytes;
        int    tape_len;
        string line;
        reset          = 1'b1;
        dl_active_i    = 1'b0;
        dl_index_i     = 8'h00;
        dl_wr_i        = 1'b0;
        dl_addr_i      = '0;
        dl_data_i      = 8'h00;
        no_header_i    = 1'b0;
        p2_h_i         = 1'b1;
        tap_credit_i   = 1'b0;
        p2_count       = 0;
        cycle_count    = 0;
        cycle_limit    = 1000000;
        reset_pulses   = 0;
        restart_pulses = 0;
        outstanding    = 0;
        credit_pending = 0;
        credit_wait    = 0;
        total_bytes    = 0;
        tape_len       = 0;
        void'($urandom(32'h65e0_03c8));

        fd = $fopen("loader_cases.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open loader_cases.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            split_line(line);
            if (toks.size() > 7 && toks[0].getc(0) != "#") begin
                case_lines.push_back(line);
                total_bytes = total_bytes + toks[6].atohex();
                if (loader_pkg::byte_t'(toks[1].atohex()) == loader_pkg::IDX_TAP) begin
                    tape_len = tape_len + toks[6].atohex();
                end
            end
        end
        $fclose(fd);
        if (case_lines.size() == 0) begin
            abort_run("No test cases found in loader_cases.txt");
        end
        // Download bytes, two bus phases per tape byte, then a fixed margin
        cycle_limit = total_bytes * 4 + tape_len * 16 * 2 + 500;

        repeat (2) @(posedge clk_sys);
        @(negedge clk_sys);
        reset = 1'b0;
        check_bit("reset_state", 1'b0, mem_we_o | mem_oe_o | force_reset_o);
        check_bit("reset_state", 1'b0, tap_valid_o | tap_restart_o);

        foreach (case_lines[k]) begin
            split_line(case_lines[k]);
            run_case();
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== loader_cases.txt ====
# name index start no_header reset version count data... nexp (addr data)...
# all fields after the name are hex
rom_drive 00 0000 0 0 0 2 5a a5 2 000000 5a 000001 a5
rom_pal 00 4000 0 0 0 2 11 22 2 00e000 11 00e001 22
rom_ntsc 00 6000 0 0 0 2 33 44 2 01e000 33 01e001 44
rom_basic 00 8000 0 0 0 2 55 66 2 00c000 55 00c001 66
rom_char 00 a010 0 0 0 2 77 88 2 008010 77 008011 88
prg_header 01 0000 0 0 0 5 01 12 aa bb cc b 001201 aa 001202 bb 001203 cc 00002d 03 00002e 12 00002f 03 000030 12 000031 03 000032 12 0000ae 03 0000af 12
prg_cart 41 0000 1 1 0 3 11 22 33 b 00a000 11 00a001 22 00a002 33 00002d 02 00002e a0 00002f 02 000030 a0 000031 02 000032 a0 0000ae 02 0000af a0
tap_play 81 0000 0 0 1 e 43 36 34 2d 54 41 50 45 2d 52 41 57 01 5c e 020000 43 020001 36 020002 34 020003 2d 020004 54 020005 41 020006 50 020007 45 020008 2d 020009 52 02000a 41 02000b 57 02000c 01 02000d 5c

// ==== vlog.f ====
loader_pkg.sv
download_decoder.sv
prg_loader.sv
tape_fetcher.sv
mem_arbiter.sv
loader_top.sv
loader_assert.sv
tb_loader_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_loader_top -f vlog.f -o sim_loader \
    && ./obj_dir/sim_loader \
    || { echo "run failed"; exit 1; }
